//--- ps2_pkg.sv
package ps2_pkg;

    // ------------------------------------------------------------------
    // payload types
    // ------------------------------------------------------------------

    // one byte of scan code set 2
    typedef logic [7:0] scan_code_t;

    // one character, plain 8-bit ascii
    typedef logic [7:0] ascii_t;

    // ------------------------------------------------------------------
    // frame layout
    // ------------------------------------------------------------------

    // start, 8 data bits lsb first, odd parity, stop
    localparam int FRAME_BITS = 11;

    // ------------------------------------------------------------------
    // special scan codes, set 2
    // ------------------------------------------------------------------

    // next byte is a release
    localparam scan_code_t BREAK_PREFIX = 8'hf0;

    // next byte is from the extended key block
    localparam scan_code_t EXT_PREFIX = 8'he0;

    // modifier keys
    localparam scan_code_t LSHIFT_CODE = 8'h12;
    localparam scan_code_t RSHIFT_CODE = 8'h59;
    localparam scan_code_t CAPS_CODE   = 8'h58;

endpackage

//--- ps2_rx.sv
`timescale 1ns/10ps

module ps2_rx
    import ps2_pkg::*;
#(
    parameter int FILTER_LEN  = 4,
    parameter int IDLE_CYCLES = 2000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ps2_clk_async,
    input  logic                  ps2_data_async,
    output logic [FRAME_BITS-1:0] frame,
    output logic                  frame_valid
);

    localparam int FLT_W  = $clog2(FILTER_LEN + 1);
    localparam int IDLE_W = $clog2(IDLE_CYCLES + 1);
    localparam int IDX_W  = $clog2(FRAME_BITS);

    logic              clk_meta;
    logic              clk_sync;
    logic              data_meta;
    logic              data_sync;
    logic              clk_filt;
    logic [FLT_W-1:0]  flt_cnt;
    logic              flt_flip;
    logic              fall;
    logic [IDX_W-1:0]  bit_idx;
    logic [IDLE_W-1:0] idle_cnt;

    // ------------------------------------------------------------------
    // two-flop synchronizers, both lines idle high
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_meta  <= 1'b1;
            clk_sync  <= 1'b1;
            data_meta <= 1'b1;
            data_sync <= 1'b1;
        end else begin
            clk_meta  <= ps2_clk_async;
            clk_sync  <= clk_meta;
            data_meta <= ps2_data_async;
            data_sync <= data_meta;
        end
    end

    // ------------------------------------------------------------------
    // clock glitch filter
    // ------------------------------------------------------------------

    // flip once FILTER_LEN samples in a row disagree with the held level
    assign flt_flip = (clk_sync != clk_filt) && (flt_cnt == FLT_W'(FILTER_LEN - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_filt <= 1'b1;
            flt_cnt  <= '0;
        end else if (clk_sync == clk_filt) begin
            // any agreeing sample restarts the run
            flt_cnt <= '0;
        end else if (flt_flip) begin
            clk_filt <= clk_sync;
            flt_cnt  <= '0;
        end else begin
            flt_cnt <= flt_cnt + 1'b1;
        end
    end

    // filtered falling edge, high-to-low flip
    assign fall = flt_flip & clk_filt;

    // ------------------------------------------------------------------
    // frame capture and idle timeout
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_idx     <= '0;
            idle_cnt    <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_idx == IDX_W'(FRAME_BITS - 1)) begin
                    // stop bit sampled, frame complete
                    bit_idx     <= '0;
                    frame_valid <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else if (bit_idx != '0) begin
                // mid-frame with no edge, drop the partial frame on timeout
                if (idle_cnt == IDLE_W'(IDLE_CYCLES - 1)) begin
                    bit_idx  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // lsb first, so shift in at the top; bit 0 ends up as start
    always_ff @(posedge clk) begin
        if (fall) begin
            frame <= {data_sync, frame[FRAME_BITS-1:1]};
        end
    end

endmodule

//--- ps2_frame_check.sv
`timescale 1ns/10ps

module ps2_frame_check
    import ps2_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [FRAME_BITS-1:0] frame,
    input  logic                  frame_valid,
    output scan_code_t            byte_code,
    output logic                  byte_valid,
    output logic                  frame_error
);

    logic start_ok;
    logic stop_ok;
    logic parity_ok;
    logic frame_ok;

    // ------------------------------------------------------------------
    // frame checks
    // ------------------------------------------------------------------

    // start low, stop high
    assign start_ok = (frame[0] == 1'b0);
    assign stop_ok  = (frame[FRAME_BITS-1] == 1'b1);

    // odd parity over data plus parity bit
    assign parity_ok = ^frame[FRAME_BITS-2:1];

    assign frame_ok = start_ok & stop_ok & parity_ok;

    // one pulse per frame, either byte or error
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= frame_valid & frame_ok;
            frame_error <= frame_valid & ~frame_ok;
        end
    end

    // data bits only
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            byte_code <= frame[8:1];
        end
    end

endmodule

//--- ps2_key_tracker.sv
`timescale 1ns/10ps

module ps2_key_tracker
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  scan_code_t byte_code,
    input  logic       byte_valid,
    output scan_code_t key_code,
    output logic       key_make,
    output logic       key_ext,
    output logic       key_valid,
    output logic       shift,
    output logic       caps_lock
);

    logic pend_break;
    logic pend_ext;
    logic lshift_held;
    logic rshift_held;
    logic caps_held;
    logic is_prefix;

    assign is_prefix = (byte_code == BREAK_PREFIX) || (byte_code == EXT_PREFIX);

    // ------------------------------------------------------------------
    // prefix decode and modifier state
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_break  <= 1'b0;
            pend_ext    <= 1'b0;
            lshift_held <= 1'b0;
            rshift_held <= 1'b0;
            caps_held   <= 1'b0;
            caps_lock   <= 1'b0;
            key_valid   <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (byte_valid) begin
                if (byte_code == BREAK_PREFIX) begin
                    pend_break <= 1'b1;
                end else if (byte_code == EXT_PREFIX) begin
                    pend_ext <= 1'b1;
                end else begin
                    // real key byte, emit event and clear prefixes
                    key_valid  <= 1'b1;
                    pend_break <= 1'b0;
                    pend_ext   <= 1'b0;
                    // extended codes leave modifiers alone
                    if (!pend_ext) begin
                        case (byte_code)
                            LSHIFT_CODE: lshift_held <= ~pend_break;
                            RSHIFT_CODE: rshift_held <= ~pend_break;
                            CAPS_CODE: begin
                                // toggle on first make only, typematic repeats ignored
                                if (pend_break) begin
                                    caps_held <= 1'b0;
                                end else if (!caps_held) begin
                                    caps_held <= 1'b1;
                                    caps_lock <= ~caps_lock;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
            end
        end
    end

    // event payload
    always_ff @(posedge clk) begin
        if (byte_valid && !is_prefix) begin
            key_code <= byte_code;
            key_make <= ~pend_break;
            key_ext  <= pend_ext;
        end
    end

    // either shift key
    assign shift = lshift_held | rshift_held;

endmodule

//--- ps2_ascii_map.sv
`timescale 1ns/10ps

module ps2_ascii_map
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  scan_code_t key_code,
    input  logic       key_make,
    input  logic       key_ext,
    input  logic       key_valid,
    input  logic       shift,
    input  logic       caps_lock,
    output ascii_t     char_code,
    output logic       char_valid
);

    // table entry: {hit, is_letter, plain char, shifted char}
    logic [17:0] entry;
    logic        hit;
    logic        is_letter;
    ascii_t      plain_char;
    ascii_t      shifted_char;
    logic        use_shifted;

    // ------------------------------------------------------------------
    // scan code set 2 lookup, us layout
    // ------------------------------------------------------------------
    always_comb begin
        case (key_code)
            // letters
            8'h1c: entry = {2'b11, "a", "A"};
            8'h32: entry = {2'b11, "b", "B"};
            8'h21: entry = {2'b11, "c", "C"};
            8'h23: entry = {2'b11, "d", "D"};
            8'h24: entry = {2'b11, "e", "E"};
            8'h2b: entry = {2'b11, "f", "F"};
            8'h34: entry = {2'b11, "g", "G"};
            8'h33: entry = {2'b11, "h", "H"};
            8'h43: entry = {2'b11, "i", "I"};
            8'h3b: entry = {2'b11, "j", "J"};
            8'h42: entry = {2'b11, "k", "K"};
            8'h4b: entry = {2'b11, "l", "L"};
            8'h3a: entry = {2'b11, "m", "M"};
            8'h31: entry = {2'b11, "n", "N"};
            8'h44: entry = {2'b11, "o", "O"};
            8'h4d: entry = {2'b11, "p", "P"};
            8'h15: entry = {2'b11, "q", "Q"};
            8'h2d: entry = {2'b11, "r", "R"};
            8'h1b: entry = {2'b11, "s", "S"};
            8'h2c: entry = {2'b11, "t", "T"};
            8'h3c: entry = {2'b11, "u", "U"};
            8'h2a: entry = {2'b11, "v", "V"};
            8'h1d: entry = {2'b11, "w", "W"};
            8'h22: entry = {2'b11, "x", "X"};
            8'h35: entry = {2'b11, "y", "Y"};
            8'h1a: entry = {2'b11, "z", "Z"};
            // top-row digits and their shifted symbols
            8'h45: entry = {2'b10, "0", ")"};
            8'h16: entry = {2'b10, "1", "!"};
            8'h1e: entry = {2'b10, "2", "@"};
            8'h26: entry = {2'b10, "3", "#"};
            8'h25: entry = {2'b10, "4", "$"};
            8'h2e: entry = {2'b10, "5", "%"};
            8'h36: entry = {2'b10, "6", "^"};
            8'h3d: entry = {2'b10, "7", "&"};
            8'h3e: entry = {2'b10, "8", "*"};
            8'h46: entry = {2'b10, "9", "("};
            // whitespace and control, same with shift
            8'h29: entry = {2'b10, 8'h20, 8'h20};
            8'h5a: entry = {2'b10, 8'h0d, 8'h0d};
            8'h66: entry = {2'b10, 8'h08, 8'h08};
            default: entry = '0;
        endcase
    end

    assign hit          = entry[17];
    assign is_letter    = entry[16];
    assign plain_char   = entry[15:8];
    assign shifted_char = entry[7:0];

    // caps only flips letters
    assign use_shifted = is_letter ? (shift ^ caps_lock) : shift;

    // presses of mapped, non-extended keys only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            char_valid <= 1'b0;
        end else begin
            char_valid <= key_valid & key_make & ~key_ext & hit;
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid) begin
            char_code <= use_shifted ? shifted_char : plain_char;
        end
    end

endmodule

//--- ps2_keyboard_top.sv
`timescale 1ns/10ps

module ps2_keyboard_top
    import ps2_pkg::*;
#(
    parameter int FILTER_LEN  = 4,
    parameter int IDLE_CYCLES = 2000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk_async,
    input  logic       ps2_data_async,
    output logic       frame_error,
    output scan_code_t key_code,
    output logic       key_make,
    output logic       key_ext,
    output logic       key_valid,
    output logic       shift,
    output logic       caps_lock,
    output ascii_t     char_code,
    output logic       char_valid
);

    // ------------------------------------------------------------------
    // stage links
    // ------------------------------------------------------------------
    logic [FRAME_BITS-1:0] frame;
    logic                  frame_valid;
    scan_code_t            byte_code;
    logic                  byte_valid;

    // line sync, clock filter, frame capture
    ps2_rx #(
        .FILTER_LEN  (FILTER_LEN),
        .IDLE_CYCLES (IDLE_CYCLES)
    ) ps2_rx_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ps2_clk_async  (ps2_clk_async),
        .ps2_data_async (ps2_data_async),
        .frame          (frame),
        .frame_valid    (frame_valid)
    );

    // start, parity, stop
    ps2_frame_check ps2_frame_check_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame       (frame),
        .frame_valid (frame_valid),
        .byte_code   (byte_code),
        .byte_valid  (byte_valid),
        .frame_error (frame_error)
    );

    // prefixes, shift and caps
    ps2_key_tracker ps2_key_tracker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_code  (byte_code),
        .byte_valid (byte_valid),
        .key_code   (key_code),
        .key_make   (key_make),
        .key_ext    (key_ext),
        .key_valid  (key_valid),
        .shift      (shift),
        .caps_lock  (caps_lock)
    );

    // press events to ascii
    ps2_ascii_map ps2_ascii_map_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_code   (key_code),
        .key_make   (key_make),
        .key_ext    (key_ext),
        .key_valid  (key_valid),
        .shift      (shift),
        .caps_lock  (caps_lock),
        .char_code  (char_code),
        .char_valid (char_valid)
    );

endmodule

//--- tb_ps2_keyboard.sv
`timescale 1ns/10ps

module tb_ps2_keyboard;
    import ps2_pkg::*;

    localparam int FILTER_LEN   = 4;
    localparam int IDLE_CYCLES  = 2000;
    localparam int HALF_BIT     = 12;
    // frames per test in order, two per random key at most
    localparam int MAX_FRAMES   = 21 + 15 + 23 + 18 + 5 + 1 + 2 * 40;
    localparam int IDLE_GAP     = IDLE_CYCLES + 200;
    localparam int LIMIT_CYCLES = 2 * MAX_FRAMES * FRAME_BITS * 2 * HALF_BIT + IDLE_GAP;

    // set 2 codes for a..z and 0..9 in character order
    localparam scan_code_t LETTER_CODES [26] = '{
        8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b,
        8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c,
        8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a};
    localparam scan_code_t DIGIT_CODES [10] = '{
        8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46};

    logic       clk;
    logic       rst_n;
    logic       ps2_clk_async;
    logic       ps2_data_async;
    logic       frame_error;
    scan_code_t key_code;
    logic       key_make;
    logic       key_ext;
    logic       key_valid;
    logic       shift;
    logic       caps_lock;
    ascii_t     char_code;
    logic       char_valid;

    // expected results with the oldest first
    logic [9:0] exp_keys[$];
    logic [1:0] exp_flags[$];
    ascii_t     exp_chars[$];
    int         exp_errors;
    string      test_name;
    integer     seed;

    // reference keyboard state
    logic ref_break;
    logic ref_ext;
    logic ref_lshift;
    logic ref_rshift;
    logic ref_caps_held;
    logic ref_caps;

    ps2_keyboard_top #(
        .FILTER_LEN  (FILTER_LEN),
        .IDLE_CYCLES (IDLE_CYCLES)
    ) ps2_keyboard_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ps2_clk_async  (ps2_clk_async),
        .ps2_data_async (ps2_data_async),
        .frame_error    (frame_error),
        .key_code       (key_code),
        .key_make       (key_make),
        .key_ext        (key_ext),
        .key_valid      (key_valid),
        .shift          (shift),
        .caps_lock      (caps_lock),
        .char_code      (char_code),
        .char_valid     (char_valid)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // failure reporting and compares
    // ------------------------------------------------------------------
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_key(input string name, input scan_code_t exp_code,
                             input logic exp_make, input logic exp_ext,
                             input scan_code_t act_code, input logic act_make,
                             input logic act_ext);
        if (act_code !== exp_code || act_make !== exp_make || act_ext !== exp_ext) begin
            stop_with_failure($sformatf(
                "mismatch %s key: expected %h make %b ext %b, actual %h make %b ext %b",
                name, exp_code, exp_make, exp_ext, act_code, act_make, act_ext));
        end
    endtask

    task automatic check_char(input string name, input ascii_t exp_char, input ascii_t act_char);
        if (act_char !== exp_char) begin
            stop_with_failure($sformatf("mismatch %s char: expected %h, actual %h",
                                        name, exp_char, act_char));
        end
    endtask

    task automatic check_flags(input string name, input logic exp_shift, input logic exp_caps,
                               input logic act_shift, input logic act_caps);
        if (act_shift !== exp_shift || act_caps !== exp_caps) begin
            stop_with_failure($sformatf(
                "mismatch %s flags: expected shift %b caps %b, actual shift %b caps %b",
                name, exp_shift, exp_caps, act_shift, act_caps));
        end
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------

    // us layout lookup that returns 1 when the key has a character
    function automatic logic lookup_char(input scan_code_t code, input logic shift_on,
                                         input logic caps_on, output ascii_t ch);
        string digit_syms;
        digit_syms = ")!@#$%^&*(";
        ch = 8'h00;
        for (int i = 0; i < 26; i++) begin
            if (code == LETTER_CODES[i]) begin
                // 'A' or 'a' plus offset
                ch = (shift_on ^ caps_on) ? ascii_t'(8'h41 + i) : ascii_t'(8'h61 + i);
                return 1'b1;
            end
        end
        for (int i = 0; i < 10; i++) begin
            if (code == DIGIT_CODES[i]) begin
                ch = shift_on ? digit_syms[i] : ascii_t'(8'h30 + i);
                return 1'b1;
            end
        end
        case (code)
            8'h29: ch = 8'h20;
            8'h5a: ch = 8'h0d;
            8'h66: ch = 8'h08;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    // queues whatever the DUT must produce for one received byte
    function automatic void model_byte(input scan_code_t b);
        ascii_t ch;
        logic   shift_now;
        if (b == BREAK_PREFIX) begin
            ref_break = 1'b1;
        end else if (b == EXT_PREFIX) begin
            ref_ext = 1'b1;
        end else begin
            if (!ref_ext && b == LSHIFT_CODE) begin
                ref_lshift = ~ref_break;
            end
            if (!ref_ext && b == RSHIFT_CODE) begin
                ref_rshift = ~ref_break;
            end
            // caps toggles once per physical press
            if (!ref_ext && b == CAPS_CODE) begin
                if (ref_break) begin
                    ref_caps_held = 1'b0;
                end else if (!ref_caps_held) begin
                    ref_caps_held = 1'b1;
                    ref_caps      = ~ref_caps;
                end
            end
            shift_now = ref_lshift | ref_rshift;
            exp_keys.push_back({b, ~ref_break, ref_ext});
            exp_flags.push_back({shift_now, ref_caps});
            if (!ref_break && !ref_ext && lookup_char(b, shift_now, ref_caps, ch)) begin
                exp_chars.push_back(ch);
            end
            ref_break = 1'b0;
            ref_ext   = 1'b0;
        end
    endfunction

    // ------------------------------------------------------------------
    // device model
    // ------------------------------------------------------------------

    // data is set while the clock is high and the device pulls the clock low mid bit
    task automatic drive_bit(input logic b);
        ps2_data_async <= b;
        repeat (HALF_BIT) @(posedge clk);
        ps2_clk_async <= 1'b0;
        repeat (HALF_BIT) @(posedge clk);
        ps2_clk_async <= 1'b1;
    endtask

    task automatic send_frame(input scan_code_t b, input logic bad_parity, input logic bad_stop);
        logic [FRAME_BITS-1:0] bits;
        bits = {~bad_stop, (~^b) ^ bad_parity, b, 1'b0};
        @(posedge clk);
        for (int i = 0; i < FRAME_BITS; i++) begin
            drive_bit(bits[i]);
        end
        ps2_data_async <= 1'b1;
        // idle between frames
        repeat (2 * HALF_BIT) @(posedge clk);
    endtask

    // first nbits of a frame with the line left idle afterwards
    task automatic send_partial(input scan_code_t b, input int nbits);
        logic [FRAME_BITS-1:0] bits;
        bits = {1'b1, ~^b, b, 1'b0};
        @(posedge clk);
        for (int i = 0; i < nbits; i++) begin
            drive_bit(bits[i]);
        end
        ps2_data_async <= 1'b1;
    endtask

    task automatic send_byte(input scan_code_t b);
        model_byte(b);
        send_frame(b, 1'b0, 1'b0);
    endtask

    task automatic send_bad(input scan_code_t b, input logic bad_parity, input logic bad_stop);
        exp_errors++;
        send_frame(b, bad_parity, bad_stop);
    endtask

    task automatic press(input scan_code_t code);
        send_byte(code);
    endtask

    task automatic release_key(input scan_code_t code);
        send_byte(BREAK_PREFIX);
        send_byte(code);
    endtask

    task automatic tap(input scan_code_t code);
        press(code);
        release_key(code);
    endtask

    task automatic ext_tap(input scan_code_t code);
        send_byte(EXT_PREFIX);
        send_byte(code);
        send_byte(EXT_PREFIX);
        send_byte(BREAK_PREFIX);
        send_byte(code);
    endtask

    // letters, digits, then modifiers and whitespace
    function automatic scan_code_t pool_code(input int idx);
        if (idx < 26) begin
            return LETTER_CODES[idx];
        end else if (idx < 36) begin
            return DIGIT_CODES[idx - 26];
        end
        case (idx)
            36: return LSHIFT_CODE;
            37: return RSHIFT_CODE;
            38: return CAPS_CODE;
            39: return 8'h29;
            40: return 8'h5a;
            default: return 8'h66;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // monitor sampled away from the active edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin : monitor
        logic [9:0] key_exp;
        logic [1:0] flags_exp;
        if (rst_n) begin
            if (key_valid) begin
                if (exp_keys.size() == 0) begin
                    stop_with_failure("key event seen while none was expected");
                end else begin
                    key_exp   = exp_keys.pop_front();
                    flags_exp = exp_flags.pop_front();
                    check_key(test_name, key_exp[9:2], key_exp[1], key_exp[0],
                              key_code, key_make, key_ext);
                    check_flags(test_name, flags_exp[1], flags_exp[0], shift, caps_lock);
                end
            end
            if (char_valid) begin
                if (exp_chars.size() == 0) begin
                    stop_with_failure("character seen while none was expected");
                end else begin
                    check_char(test_name, exp_chars.pop_front(), char_code);
                end
            end
            if (frame_error) begin
                if (exp_errors == 0) begin
                    stop_with_failure("frame error on a frame that was sent correctly");
                end else begin
                    exp_errors--;
                end
            end
        end
    end

    // watchdog
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        stop_with_failure("timeout: the run did not finish in the allowed time");
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        int pick;
        int wait_cycles;
        clk            = 1'b0;
        rst_n          = 1'b0;
        ps2_clk_async  = 1'b1;
        ps2_data_async = 1'b1;
        seed           = 32'h6c09ef24;
        exp_errors     = 0;
        ref_break      = 1'b0;
        ref_ext        = 1'b0;
        ref_lshift     = 1'b0;
        ref_rshift     = 1'b0;
        ref_caps_held  = 1'b0;
        ref_caps       = 1'b0;
        test_name      = "reset";
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flags(test_name, 1'b0, 1'b0, shift, caps_lock);

        // a, b, 0, 1, space, enter, backspace
        test_name = "plain";
        tap(8'h1c);
        tap(8'h32);
        tap(8'h45);
        tap(8'h16);
        tap(8'h29);
        tap(8'h5a);
        tap(8'h66);

        // overlapping shifts keep shift high
        test_name = "shift";
        press(LSHIFT_CODE);
        tap(8'h1c);
        tap(8'h16);
        press(RSHIFT_CODE);
        release_key(LSHIFT_CODE);
        tap(8'h21);
        release_key(RSHIFT_CODE);

        // typematic caps makes and then shift over caps
        test_name = "caps";
        press(CAPS_CODE);
        press(CAPS_CODE);
        press(CAPS_CODE);
        release_key(CAPS_CODE);
        tap(8'h1c);
        // caps alone leaves digits plain
        tap(8'h1e);
        press(LSHIFT_CODE);
        tap(8'h1c);
        tap(8'h1e);
        release_key(LSHIFT_CODE);
        tap(CAPS_CODE);

        // e0 12, arrow up, keypad enter
        test_name = "extended";
        ext_tap(LSHIFT_CODE);
        ext_tap(8'h75);
        ext_tap(8'h5a);
        tap(8'h32);

        test_name = "bad_frame";
        send_bad(8'h1c, 1'b1, 1'b0);
        send_bad(8'h32, 1'b0, 1'b1);
        tap(8'h1c);

        // partial frame must time out in the receiver
        test_name = "truncated";
        send_partial(8'h1c, 5);
        repeat (IDLE_GAP) @(posedge clk);

        test_name = "random";
        for (int n = 0; n < 40; n++) begin
            pick = $unsigned($random(seed)) % 42;
            if ($random(seed) & 1) begin
                press(pool_code(pick));
            end else begin
                release_key(pool_code(pick));
            end
        end

        // let the pipeline empty out
        test_name   = "drain";
        wait_cycles = 0;
        while ((exp_keys.size() != 0 || exp_chars.size() != 0 || exp_errors != 0)
               && wait_cycles < 100) begin
            @(posedge clk);
            wait_cycles++;
        end
        @(negedge clk);
        if (exp_keys.size() != 0 || exp_chars.size() != 0 || exp_errors != 0) begin
            stop_with_failure($sformatf(
                "expected results never arrived: %0d key events, %0d characters, %0d errors",
                exp_keys.size(), exp_chars.size(), exp_errors));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- files.f
ps2_pkg.sv
ps2_rx.sv
ps2_frame_check.sv
ps2_key_tracker.sv
ps2_ascii_map.sv
ps2_keyboard_top.sv
tb_ps2_keyboard.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ps2_keyboard
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
